/* src/pmp_pkg.sv */
// Widths, region flag positions, data opcode and requester state enums
package pmp_pkg;

    // Bus widths
    localparam int ADDR_W = 32;  // Word address
    localparam int DATA_W = 32;  // Memory word

    // Region flags, packed as {valid, lock, read, write, execute}
    localparam int FL_W     = 5;
    localparam int FL_X     = 0;
    localparam int FL_W_BIT = 1;
    localparam int FL_R     = 2;
    localparam int FL_L     = 3;
    localparam int FL_V     = 4;

    // Data port opcode
    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } mem_op_e;

    // Shared requester FSM states
    typedef enum logic [2:0] {
        IDLE      = 3'd0,  // Waiting for a request
        CHECK     = 3'd1,  // Address is in the permission lookup
        WAIT_GNT  = 3'd2,  // Requesting the memory
        WAIT_DATA = 3'd3,  // Read issued, data arrives this cycle
        RESP      = 3'd4   // Holding the response
    } port_state_e;

endpackage

/* src/pmp_table.sv */
// Region table registers with the fetch and data permission lookup
`timescale 1ns/1ns

module pmp_table #(
    parameter int PMP_REGIONS = 4,
    localparam int RGN_W = (PMP_REGIONS > 1) ? $clog2(PMP_REGIONS) : 1
) (
    input  logic                       i_clk,
    input  logic                       i_nrst,
    input  logic                       i_ena,     // Global protection enable
    input  logic                       i_we,      // Region write strobe
    input  logic [RGN_W-1:0]           i_region,
    input  logic [pmp_pkg::ADDR_W-1:0] i_start,
    input  logic [pmp_pkg::ADDR_W-1:0] i_end,     // Inclusive
    input  logic [pmp_pkg::FL_W-1:0]   i_flags,
    input  logic [pmp_pkg::ADDR_W-1:0] i_iaddr,   // Fetch address
    input  logic [pmp_pkg::ADDR_W-1:0] i_daddr,   // Data address
    output logic                       o_r,
    output logic                       o_w,
    output logic                       o_x
);

    import pmp_pkg::*;

    logic [ADDR_W-1:0] start_q [PMP_REGIONS];
    logic [ADDR_W-1:0] end_q   [PMP_REGIONS];
    logic [FL_W-1:0]   flags_q [PMP_REGIONS];

    // Table update, an invalid entry keeps no range
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            for (int i = 0; i < PMP_REGIONS; i++) begin
                start_q[i] <= '0;
                end_q[i]   <= '0;
                flags_q[i] <= '0;
            end
        end else if (i_we) begin
            start_q[i_region] <= i_flags[FL_V] ? i_start : '0;
            end_q[i_region]   <= i_flags[FL_V] ? i_end : '0;
            flags_q[i_region] <= i_flags;
        end
    end

    // Lookup walks from the top index down so the lowest match is applied last
    always_comb begin
        o_x = ~i_ena;  // Unmatched access is allowed only when protection is off
        o_r = ~i_ena;
        o_w = ~i_ena;
        for (int i = PMP_REGIONS - 1; i >= 0; i--) begin
            // Locked regions apply regardless of the enable
            if (flags_q[i][FL_V] && (i_ena || flags_q[i][FL_L])) begin
                if ((i_iaddr >= start_q[i]) && (i_iaddr <= end_q[i])) begin
                    o_x = flags_q[i][FL_X];
                end
                if ((i_daddr >= start_q[i]) && (i_daddr <= end_q[i])) begin
                    o_r = flags_q[i][FL_R];
                    o_w = flags_q[i][FL_W_BIT];
                end
            end
        end
    end

endmodule

/* src/pmp_cfg_port.sv */
// Region configuration write port with handshake and lock enforcement
`timescale 1ns/1ns

module pmp_cfg_port #(
    parameter int PMP_REGIONS = 4,
    localparam int RGN_W = (PMP_REGIONS > 1) ? $clog2(PMP_REGIONS) : 1
) (
    input  logic                       i_clk,
    input  logic                       i_nrst,
    input  logic                       i_cfg_valid,
    input  logic [RGN_W-1:0]           i_cfg_region,
    input  logic [pmp_pkg::ADDR_W-1:0] i_cfg_start,
    input  logic [pmp_pkg::ADDR_W-1:0] i_cfg_end,
    input  logic [pmp_pkg::FL_W-1:0]   i_cfg_flags,
    output logic                       o_cfg_ready,
    output logic                       o_we,      // One-cycle table write
    output logic [RGN_W-1:0]           o_region,
    output logic [pmp_pkg::ADDR_W-1:0] o_start,
    output logic [pmp_pkg::ADDR_W-1:0] o_end,
    output logic [pmp_pkg::FL_W-1:0]   o_flags
);

    import pmp_pkg::*;

    logic                   busy_q;  // Cycle after an accepted write
    logic [PMP_REGIONS-1:0] lock_q;  // Regions frozen until reset
    logic                   accept;
    logic                   pass;    // Accepted and target not locked

    assign o_cfg_ready = ~busy_q;
    assign accept      = i_cfg_valid & o_cfg_ready;
    assign pass        = accept & ~lock_q[i_cfg_region];

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            busy_q <= 1'b0;
            o_we   <= 1'b0;
            lock_q <= '0;
        end else begin
            busy_q <= accept;
            o_we   <= pass;  // Locked writes vanish here
            if (pass && i_cfg_flags[FL_L] && i_cfg_flags[FL_V]) begin
                lock_q[i_cfg_region] <= 1'b1;
            end
        end
    end

    // Write payload, only meaningful while o_we is high
    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_region <= i_cfg_region;
            o_start  <= i_cfg_start;
            o_end    <= i_cfg_end;
            o_flags  <= i_cfg_flags;
        end
    end

endmodule

/* src/fetch_port.sv */
// Instruction fetch requester with execute check and arbitrated memory read
`timescale 1ns/1ns

module fetch_port (
    input  logic                       i_clk,
    input  logic                       i_nrst,
    input  logic                       i_f_valid,
    input  logic [pmp_pkg::ADDR_W-1:0] i_f_addr,
    output logic                       o_f_ready,
    output logic                       o_f_rsp_valid,
    output logic [pmp_pkg::DATA_W-1:0] o_f_rsp_data,
    output logic                       o_f_rsp_fault,
    input  logic                       i_f_rsp_ready,
    output logic [pmp_pkg::ADDR_W-1:0] o_chk_addr,  // To the table lookup
    input  logic                       i_perm_x,
    output logic                       o_req,
    output logic [pmp_pkg::ADDR_W-1:0] o_addr,
    input  logic                       i_gnt,
    input  logic [pmp_pkg::DATA_W-1:0] i_rdata
);

    import pmp_pkg::*;

    port_state_e       state_q;
    logic              fault_q;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] data_q;

    assign o_f_ready     = (state_q == IDLE);
    assign o_f_rsp_valid = (state_q == RESP);
    assign o_f_rsp_data  = data_q;
    assign o_f_rsp_fault = fault_q;
    assign o_chk_addr    = addr_q;
    assign o_addr        = addr_q;
    assign o_req         = (state_q == WAIT_GNT);

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state_q <= IDLE;
            fault_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE:      if (i_f_valid) state_q <= CHECK;
                CHECK: begin
                    fault_q <= ~i_perm_x;
                    state_q <= i_perm_x ? WAIT_GNT : RESP;
                end
                WAIT_GNT:  if (i_gnt) state_q <= WAIT_DATA;
                WAIT_DATA: state_q <= RESP;
                RESP:      if (i_f_rsp_ready) state_q <= IDLE;
                default:   state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_f_ready && i_f_valid) begin
            addr_q <= i_f_addr;
        end
        if (state_q == CHECK) begin
            data_q <= '0;       // Faulted fetch returns zero
        end else if (state_q == WAIT_DATA) begin
            data_q <= i_rdata;  // Memory output from the grant edge
        end
    end

endmodule

/* src/data_port.sv */
// Load and store requester with read or write check and arbitrated access
`timescale 1ns/1ns

module data_port (
    input  logic                       i_clk,
    input  logic                       i_nrst,
    input  logic                       i_d_valid,
    input  pmp_pkg::mem_op_e           i_d_op,
    input  logic [pmp_pkg::ADDR_W-1:0] i_d_addr,
    input  logic [pmp_pkg::DATA_W-1:0] i_d_wdata,
    output logic                       o_d_ready,
    output logic                       o_d_rsp_valid,
    output logic [pmp_pkg::DATA_W-1:0] o_d_rsp_data,
    output logic                       o_d_rsp_fault,
    input  logic                       i_d_rsp_ready,
    output logic [pmp_pkg::ADDR_W-1:0] o_chk_addr,
    input  logic                       i_perm_r,
    input  logic                       i_perm_w,
    output logic                       o_req,
    output logic                       o_we,
    output logic [pmp_pkg::ADDR_W-1:0] o_addr,
    output logic [pmp_pkg::DATA_W-1:0] o_wdata,
    input  logic                       i_gnt,
    input  logic [pmp_pkg::DATA_W-1:0] i_rdata
);

    import pmp_pkg::*;

    port_state_e       state_q;
    logic              fault_q;
    mem_op_e           op_q;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] wdata_q;
    logic [DATA_W-1:0] data_q;
    logic              allowed;

    // Permission needed depends on the latched opcode
    assign allowed = (op_q == OP_STORE) ? i_perm_w : i_perm_r;

    assign o_d_ready     = (state_q == IDLE);
    assign o_d_rsp_valid = (state_q == RESP);
    assign o_d_rsp_data  = data_q;
    assign o_d_rsp_fault = fault_q;
    assign o_chk_addr    = addr_q;
    assign o_req         = (state_q == WAIT_GNT);
    assign o_we          = (op_q == OP_STORE);
    assign o_addr        = addr_q;
    assign o_wdata       = wdata_q;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state_q <= IDLE;
            fault_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: if (i_d_valid) state_q <= CHECK;
                CHECK: begin
                    fault_q <= ~allowed;
                    state_q <= allowed ? WAIT_GNT : RESP;
                end
                WAIT_GNT: begin
                    if (i_gnt) begin
                        // Store is done at the grant edge
                        state_q <= (op_q == OP_STORE) ? RESP : WAIT_DATA;
                    end
                end
                WAIT_DATA: state_q <= RESP;
                RESP:      if (i_d_rsp_ready) state_q <= IDLE;
                default:   state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_d_ready && i_d_valid) begin
            op_q    <= i_d_op;
            addr_q  <= i_d_addr;
            wdata_q <= i_d_wdata;
        end
        if (state_q == CHECK) begin
            data_q <= '0;  // Stays zero for stores and faults
        end else if (state_q == WAIT_DATA) begin
            data_q <= i_rdata;
        end
    end

endmodule

/* src/mem_arbiter.sv */
// Round-robin arbiter between the fetch and data ports onto one memory
`timescale 1ns/1ns

module mem_arbiter (
    input  logic                       i_clk,
    input  logic                       i_nrst,
    input  logic                       i_req0,    // Fetch, read only
    input  logic [pmp_pkg::ADDR_W-1:0] i_addr0,
    input  logic                       i_req1,    // Data
    input  logic                       i_we1,
    input  logic [pmp_pkg::ADDR_W-1:0] i_addr1,
    input  logic [pmp_pkg::DATA_W-1:0] i_wdata1,
    output logic                       o_gnt0,
    output logic                       o_gnt1,
    output logic                       o_mem_en,
    output logic                       o_mem_we,
    output logic [pmp_pkg::ADDR_W-1:0] o_mem_addr,
    output logic [pmp_pkg::DATA_W-1:0] o_mem_wdata
);

    logic last1_q;  // Port 1 won the previous grant

    // On a conflict the port that lost last time goes first
    assign o_gnt0 = i_req0 & (~i_req1 | last1_q);
    assign o_gnt1 = i_req1 & (~i_req0 | ~last1_q);

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            last1_q <= 1'b1;  // Fetch wins the first conflict
        end else if (o_gnt0 || o_gnt1) begin
            last1_q <= o_gnt1;
        end
    end

    // Memory side follows the winner
    assign o_mem_en    = o_gnt0 | o_gnt1;
    assign o_mem_we    = o_gnt1 & i_we1;
    assign o_mem_addr  = o_gnt1 ? i_addr1 : i_addr0;
    assign o_mem_wdata = i_wdata1;  // Only port 1 writes

endmodule

/* src/prot_mem.sv */
// Single-port word memory with synchronous write and registered read
`timescale 1ns/1ns

module prot_mem #(
    parameter int MEM_WORDS = 256,
    localparam int MEM_AW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1
) (
    input  logic                       i_clk,
    input  logic                       i_en,
    input  logic                       i_we,
    input  logic [pmp_pkg::ADDR_W-1:0] i_addr,   // Low bits select the word
    input  logic [pmp_pkg::DATA_W-1:0] i_wdata,
    output logic [pmp_pkg::DATA_W-1:0] o_rdata   // Valid the cycle after a read
);

    import pmp_pkg::*;

    logic [DATA_W-1:0] mem [MEM_WORDS];
    logic [MEM_AW-1:0] idx;

    assign idx = i_addr[MEM_AW-1:0];

    always_ff @(posedge i_clk) begin
        if (i_en) begin
            if (i_we) begin
                mem[idx] <= i_wdata;
            end else begin
                o_rdata <= mem[idx];
            end
        end
    end

endmodule

/* src/pmp_mem_top.sv */
// Protected memory subsystem top with config port, table, requesters and memory
`timescale 1ns/1ns

module pmp_mem_top #(
    parameter int PMP_REGIONS = 4,
    parameter int MEM_WORDS   = 256,
    localparam int RGN_W = (PMP_REGIONS > 1) ? $clog2(PMP_REGIONS) : 1
) (
    input  logic                       i_clk,
    input  logic                       i_nrst,
    input  logic                       i_pmp_ena,
    // Configuration
    input  logic                       i_cfg_valid,
    input  logic [RGN_W-1:0]           i_cfg_region,
    input  logic [pmp_pkg::ADDR_W-1:0] i_cfg_start,
    input  logic [pmp_pkg::ADDR_W-1:0] i_cfg_end,
    input  logic [pmp_pkg::FL_W-1:0]   i_cfg_flags,
    output logic                       o_cfg_ready,
    // Fetch
    input  logic                       i_f_valid,
    input  logic [pmp_pkg::ADDR_W-1:0] i_f_addr,
    output logic                       o_f_ready,
    output logic                       o_f_rsp_valid,
    output logic [pmp_pkg::DATA_W-1:0] o_f_rsp_data,
    output logic                       o_f_rsp_fault,
    input  logic                       i_f_rsp_ready,
    // Data
    input  logic                       i_d_valid,
    input  pmp_pkg::mem_op_e           i_d_op,
    input  logic [pmp_pkg::ADDR_W-1:0] i_d_addr,
    input  logic [pmp_pkg::DATA_W-1:0] i_d_wdata,
    output logic                       o_d_ready,
    output logic                       o_d_rsp_valid,
    output logic [pmp_pkg::DATA_W-1:0] o_d_rsp_data,
    output logic                       o_d_rsp_fault,
    input  logic                       i_d_rsp_ready
);

    import pmp_pkg::*;

    logic              cfg_we;
    logic [RGN_W-1:0]  cfg_region;
    logic [ADDR_W-1:0] cfg_start;
    logic [ADDR_W-1:0] cfg_end;
    logic [FL_W-1:0]   cfg_flags;
    logic [ADDR_W-1:0] f_chk_addr, d_chk_addr;
    logic              perm_x, perm_r, perm_w;
    logic              f_req, f_gnt, d_req, d_we, d_gnt;
    logic [ADDR_W-1:0] f_addr, d_addr;
    logic [DATA_W-1:0] d_wdata;
    logic              mem_en, mem_we;
    logic [ADDR_W-1:0] mem_addr;
    logic [DATA_W-1:0] mem_wdata, mem_rdata;

    pmp_cfg_port #(.PMP_REGIONS(PMP_REGIONS)) u_cfg (
        .i_clk(i_clk), .i_nrst(i_nrst),
        .i_cfg_valid(i_cfg_valid), .i_cfg_region(i_cfg_region),
        .i_cfg_start(i_cfg_start), .i_cfg_end(i_cfg_end),
        .i_cfg_flags(i_cfg_flags), .o_cfg_ready(o_cfg_ready),
        .o_we(cfg_we), .o_region(cfg_region), .o_start(cfg_start),
        .o_end(cfg_end), .o_flags(cfg_flags)
    );

    pmp_table #(.PMP_REGIONS(PMP_REGIONS)) u_table (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_ena(i_pmp_ena),
        .i_we(cfg_we), .i_region(cfg_region), .i_start(cfg_start),
        .i_end(cfg_end), .i_flags(cfg_flags),
        .i_iaddr(f_chk_addr), .i_daddr(d_chk_addr),
        .o_r(perm_r), .o_w(perm_w), .o_x(perm_x)
    );

    fetch_port u_fetch (
        .i_clk(i_clk), .i_nrst(i_nrst),
        .i_f_valid(i_f_valid), .i_f_addr(i_f_addr), .o_f_ready(o_f_ready),
        .o_f_rsp_valid(o_f_rsp_valid), .o_f_rsp_data(o_f_rsp_data),
        .o_f_rsp_fault(o_f_rsp_fault), .i_f_rsp_ready(i_f_rsp_ready),
        .o_chk_addr(f_chk_addr), .i_perm_x(perm_x),
        .o_req(f_req), .o_addr(f_addr), .i_gnt(f_gnt), .i_rdata(mem_rdata)
    );

    data_port u_data (
        .i_clk(i_clk), .i_nrst(i_nrst),
        .i_d_valid(i_d_valid), .i_d_op(i_d_op), .i_d_addr(i_d_addr),
        .i_d_wdata(i_d_wdata), .o_d_ready(o_d_ready),
        .o_d_rsp_valid(o_d_rsp_valid), .o_d_rsp_data(o_d_rsp_data),
        .o_d_rsp_fault(o_d_rsp_fault), .i_d_rsp_ready(i_d_rsp_ready),
        .o_chk_addr(d_chk_addr), .i_perm_r(perm_r), .i_perm_w(perm_w),
        .o_req(d_req), .o_we(d_we), .o_addr(d_addr), .o_wdata(d_wdata),
        .i_gnt(d_gnt), .i_rdata(mem_rdata)
    );

    mem_arbiter u_arb (
        .i_clk(i_clk), .i_nrst(i_nrst),
        .i_req0(f_req), .i_addr0(f_addr),
        .i_req1(d_req), .i_we1(d_we), .i_addr1(d_addr), .i_wdata1(d_wdata),
        .o_gnt0(f_gnt), .o_gnt1(d_gnt),
        .o_mem_en(mem_en), .o_mem_we(mem_we),
        .o_mem_addr(mem_addr), .o_mem_wdata(mem_wdata)
    );

    prot_mem #(.MEM_WORDS(MEM_WORDS)) u_mem (
        .i_clk(i_clk), .i_en(mem_en), .i_we(mem_we),
        .i_addr(mem_addr), .i_wdata(mem_wdata), .o_rdata(mem_rdata)
    );

endmodule

/* dv/tb_pmp_mem.sv */
// Testbench for the protected memory subsystem with reference model, checker and report
`timescale 1ns/1ns

module tb_pmp_mem;

    import pmp_pkg::*;

    localparam int REGIONS = 4;
    localparam int WORDS   = 256;
    localparam int TIMEOUT = 500;  // Cycles allowed for any single wait

    logic              i_clk;
    logic              i_nrst;
    logic              i_pmp_ena;
    logic              i_cfg_valid;
    logic [1:0]        i_cfg_region;
    logic [ADDR_W-1:0] i_cfg_start, i_cfg_end;
    logic [FL_W-1:0]   i_cfg_flags;
    logic              o_cfg_ready;
    logic              i_f_valid;
    logic [ADDR_W-1:0] i_f_addr;
    logic              o_f_ready, o_f_rsp_valid, o_f_rsp_fault;
    logic [DATA_W-1:0] o_f_rsp_data;
    logic              i_f_rsp_ready = 1'b1;
    logic              i_d_valid;
    mem_op_e           i_d_op;
    logic [ADDR_W-1:0] i_d_addr;
    logic [DATA_W-1:0] i_d_wdata;
    logic              o_d_ready, o_d_rsp_valid, o_d_rsp_fault;
    logic [DATA_W-1:0] o_d_rsp_data;
    logic              i_d_rsp_ready = 1'b1;

    // Reference model state
    logic [ADDR_W-1:0]  m_start [REGIONS];
    logic [ADDR_W-1:0]  m_end   [REGIONS];
    logic [FL_W-1:0]    m_flags [REGIONS];
    logic [REGIONS-1:0] m_lock;
    logic [DATA_W-1:0]  m_mem   [WORDS];

    logic [32:0] f_exp_q[$];  // {fault, data}
    logic [32:0] d_exp_q[$];
    int          f_when_q[$]; // Edge of the expected handshake or -1 when not timed
    int          d_when_q[$];
    int          cyc = 0;
    int          seed;
    bit          rnd_bp = 1'b0;
    string       test_name;

    pmp_mem_top #(.PMP_REGIONS(REGIONS), .MEM_WORDS(WORDS)) dut (.*);

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    always @(posedge i_clk) cyc <= cyc + 1;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            fail_run($sformatf("ERROR %s %s: expected %0h, actual %0h",
                               test_name, what, exp, act));
        end
    endtask

    // Kind 0 is a fetch, 1 a load, 2 a store; the first matching region decides
    function automatic logic [32:0] expect_rsp(input int kind, input logic [ADDR_W-1:0] addr);
        logic permit;
        int   hit;
        permit = !i_pmp_ena;
        hit    = -1;
        for (int i = 0; i < REGIONS; i++) begin
            if (hit < 0 && m_flags[i][FL_V] && (i_pmp_ena || m_flags[i][FL_L]) &&
                addr >= m_start[i] && addr <= m_end[i]) begin
                hit = i;
            end
        end
        if (hit >= 0) begin
            if (kind == 0) permit = m_flags[hit][FL_X];
            else if (kind == 1) permit = m_flags[hit][FL_R];
            else permit = m_flags[hit][FL_W_BIT];
        end
        if (permit && kind != 2) return {1'b0, m_mem[addr[7:0]]};
        return {!permit, 32'd0};  // Stores and faults carry zero data
    endfunction

    // Compare each response at the edge where it is taken
    always @(posedge i_clk) begin : compare_rsp
        logic [32:0] e;
        int          w;
        if (i_nrst && o_f_rsp_valid && i_f_rsp_ready) begin
            if (f_exp_q.size() == 0) begin
                fail_run("Fetch port returned a response that was never requested");
            end else begin
                e = f_exp_q.pop_front();
                w = f_when_q.pop_front();
                check("fetch fault", {31'd0, e[32]}, {31'd0, o_f_rsp_fault});
                check("fetch data", e[31:0], o_f_rsp_data);
                if (w >= 0) check("fetch latency", w, cyc);
            end
        end
        if (i_nrst && o_d_rsp_valid && i_d_rsp_ready) begin
            if (d_exp_q.size() == 0) begin
                fail_run("Data port returned a response that was never requested");
            end else begin
                e = d_exp_q.pop_front();
                w = d_when_q.pop_front();
                check("data fault", {31'd0, e[32]}, {31'd0, o_d_rsp_fault});
                check("data value", e[31:0], o_d_rsp_data);
                if (w >= 0) check("data latency", w, cyc);
            end
        end
    end

    always @(negedge i_clk) begin
        if (rnd_bp) begin
            i_f_rsp_ready = ($random(seed) & 3) != 0;  // Stall about a quarter of cycles
            i_d_rsp_ready = ($random(seed) & 3) != 0;
        end else begin
            i_f_rsp_ready = 1'b1;
            i_d_rsp_ready = 1'b1;
        end
    end

    task automatic apply_reset();
        i_nrst = 1'b0;
        for (int i = 0; i < REGIONS; i++) begin
            m_start[i] = '0;
            m_end[i]   = '0;
            m_flags[i] = '0;
        end
        m_lock = '0;
        repeat (2) @(negedge i_clk);
        i_nrst = 1'b1;
        check("reset outputs", 32'h1c, {27'd0, o_cfg_ready, o_f_ready, o_d_ready,
                                        o_f_rsp_valid, o_d_rsp_valid});
    endtask

    task automatic cfg_write(input logic [1:0] rgn, input logic [ADDR_W-1:0] lo, hi,
                             input logic [FL_W-1:0] fl);
        int n;
        n = 0;
        while (!o_cfg_ready) begin
            @(negedge i_clk);
            n++;
            if (n > TIMEOUT) fail_run("Timeout: configuration port never became ready");
        end
        i_cfg_valid  = 1'b1;
        i_cfg_region = rgn;
        i_cfg_start  = lo;
        i_cfg_end    = hi;
        i_cfg_flags  = fl;
        if (!m_lock[rgn]) begin  // A locked entry ignores the write
            m_start[rgn] = fl[FL_V] ? lo : '0;
            m_end[rgn]   = fl[FL_V] ? hi : '0;
            m_flags[rgn] = fl;
            if (fl[FL_L] && fl[FL_V]) m_lock[rgn] = 1'b1;
        end
        @(negedge i_clk);
        i_cfg_valid = 1'b0;
        check("cfg ready after write", 32'd0, {31'd0, o_cfg_ready});  // One busy cycle
        @(negedge i_clk);
        check("cfg ready again", 32'd1, {31'd0, o_cfg_ready});
        @(negedge i_clk);  // Entry visible two edges after acceptance
    endtask

    task automatic fetch_req(input logic [ADDR_W-1:0] addr, input bit timed);
        int          n;
        logic [32:0] e;
        n = 0;
        while (!o_f_ready) begin
            @(negedge i_clk);
            n++;
            if (n > TIMEOUT) fail_run("Timeout: fetch port never became ready for a request");
        end
        e = expect_rsp(0, addr);
        f_exp_q.push_back(e);
        f_when_q.push_back(timed ? cyc + (e[32] ? 2 : 4) : -1);
        i_f_valid = 1'b1;
        i_f_addr  = addr;
        @(negedge i_clk);
        i_f_valid = 1'b0;
    endtask

    task automatic data_req(input mem_op_e op, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata, input bit timed);
        int          n;
        int          lat;
        logic [32:0] e;
        n = 0;
        while (!o_d_ready) begin
            @(negedge i_clk);
            n++;
            if (n > TIMEOUT) fail_run("Timeout: data port never became ready for a request");
        end
        e   = expect_rsp(op == OP_STORE ? 2 : 1, addr);
        lat = e[32] ? 2 : (op == OP_STORE) ? 3 : 4;
        if (op == OP_STORE && !e[32]) m_mem[addr[7:0]] = wdata;
        d_exp_q.push_back(e);
        d_when_q.push_back(timed ? cyc + lat : -1);
        i_d_valid = 1'b1;
        i_d_op    = op;
        i_d_addr  = addr;
        i_d_wdata = wdata;
        @(negedge i_clk);
        i_d_valid = 1'b0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (f_exp_q.size() != 0 || d_exp_q.size() != 0) begin
            @(negedge i_clk);
            n++;
            if (n > TIMEOUT) fail_run("Timeout: a requested response never came back");
        end
    endtask

    // Load, fetch, store and load again with one request in flight
    task automatic probe(input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] val;
        val = $random(seed);
        data_req(OP_LOAD, addr, '0, 1'b1);
        drain();
        fetch_req(addr, 1'b1);
        drain();
        data_req(OP_STORE, addr, val, 1'b1);
        drain();
        data_req(OP_LOAD, addr, '0, 1'b1);
        drain();
    endtask

    initial begin
        logic [DATA_W-1:0] val;
        seed         = 32'hcf60_3b53;
        i_nrst       = 1'b0;
        i_pmp_ena    = 1'b0;
        i_cfg_valid  = 1'b0;
        i_cfg_region = '0;
        i_cfg_start  = '0;
        i_cfg_end    = '0;
        i_cfg_flags  = '0;
        i_f_valid    = 1'b0;
        i_f_addr     = '0;
        i_d_valid    = 1'b0;
        i_d_op       = OP_LOAD;
        i_d_addr     = '0;
        i_d_wdata    = '0;
        for (int i = 0; i < WORDS; i++) m_mem[i] = '0;
        apply_reset();

        test_name = "no_protection";
        for (int a = 0; a < 64; a++) begin  // Every word read later is written here
            val = $random(seed);
            data_req(OP_STORE, a, val, 1'b1);
            drain();
        end
        for (int a = 1; a < 64; a += 9) probe(a);

        test_name = "region_flags";
        i_pmp_ena = 1'b1;
        cfg_write(2'd0, 32'h00, 32'h0f, 5'b10110);
        cfg_write(2'd1, 32'h10, 32'h1f, 5'b10001);
        cfg_write(2'd2, 32'h20, 32'h2f, 5'b10100);
        cfg_write(2'd3, 32'h1000_0000, 32'h1000_00ff, 5'b10111);
        probe(32'h05);
        probe(32'h15);
        probe(32'h25);
        probe(32'h35);
        probe(32'h1000_0008);
        probe(32'h2000_0005);  // Outside every region but aliases word 5

        test_name = "overlap";
        cfg_write(2'd0, 32'h08, 32'h1f, 5'b10110);
        probe(32'h18);
        probe(32'h05);
        cfg_write(2'd0, 32'h08, 32'h1f, 5'b00110);  // Valid clear removes region 0
        probe(32'h18);

        test_name = "lock";
        i_pmp_ena = 1'b0;
        cfg_write(2'd2, 32'h20, 32'h2f, 5'b11100);
        probe(32'h24);
        probe(32'h15);
        cfg_write(2'd2, 32'h20, 32'h2f, 5'b10111);
        probe(32'h24);
        cfg_write(2'd2, 32'h00, 32'h00, 5'b00000);
        probe(32'h24);
        i_pmp_ena = 1'b1;
        probe(32'h24);

        test_name = "concurrent";
        apply_reset();
        i_pmp_ena = 1'b0;
        for (int i = 0; i < 4; i++) begin
            val = $random(seed);
            fork
                fetch_req(32 + i, 1'b0);
                data_req(i[0] ? OP_STORE : OP_LOAD, 8 + i, val, 1'b0);
            join
            drain();
        end
        i_pmp_ena = 1'b1;  // No regions, so both ports fault
        fork
            fetch_req(32'h30, 1'b0);
            data_req(OP_LOAD, 32'h10, '0, 1'b0);
        join
        drain();

        test_name = "random";
        cfg_write(2'd0, 32'h00, 32'h0f, 5'b10110);
        cfg_write(2'd1, 32'h10, 32'h1f, 5'b10100);
        cfg_write(2'd2, 32'h20, 32'h2f, 5'b10001);
        cfg_write(2'd3, 32'h30, 32'h37, 5'b10100);
        rnd_bp = 1'b1;
        fork
            for (int i = 0; i < 60; i++) begin  // Fetches stay clear of stored words
                fetch_req(28 + ($unsigned($random(seed)) % 36), 1'b0);
                repeat ($unsigned($random(seed)) % 3) @(negedge i_clk);
            end
            for (int i = 0; i < 60; i++) begin
                data_req(($random(seed) & 1) ? OP_STORE : OP_LOAD,
                         $unsigned($random(seed)) % 36, $random(seed), 1'b0);
                repeat ($unsigned($random(seed)) % 3) @(negedge i_clk);
            end
        join
        drain();
        rnd_bp = 1'b0;
        repeat (10) @(negedge i_clk);
        // Both ports back in IDLE with nothing left to return
        check("ports idle", 32'hc, {28'd0, o_f_ready, o_d_ready,
                                    o_f_rsp_valid, o_d_rsp_valid});

        $display("Testbench passed");
        $finish;
    end

endmodule

/* flist.f */
src/pmp_pkg.sv
src/pmp_table.sv
src/pmp_cfg_port.sv
src/fetch_port.sv
src/data_port.sv
src/mem_arbiter.sv
src/prot_mem.sv
src/pmp_mem_top.sv
dv/tb_pmp_mem.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns -j 0 \
    -f flist.f --top-module tb_pmp_mem \
    --Mdir obj_dir -o tb_pmp_mem_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build returned status $status"
    exit "$status"
fi

./obj_dir/tb_pmp_mem_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation returned status $status"
    exit "$status"
fi

exit 0
